// File: bench/cp0_tb.sv
`include "cp0_cfg.svh"

module cp0_tb;
    import cp0_reg_pkg::*;
    import exc_pkg::*;

    logic        clk, rst_n, we_i, store_i, commit_valid_i, commit_bd_i, eret_i;
    logic        trap_o, user_mode_o;
    cp0_reg_e    rd_addr_i, wr_addr_i;
    logic [31:0] rd_data_o, wr_data_i, commit_pc_i, mem_addr_i, trap_vector_o, eret_target_o;
    logic [`HW_INT_LINES-1:0]       hw_int_i;
    logic [EXC_FLAG_COUNT-1:0]      exc_flags_i;
    tlb_config_t tlb_config_o;
    exc_code_e   trap_code_o, exp_code;

    logic [31:0] m [0:31];          // Reference copy of each register's readback.
    logic [31:0] known, exp_rd, exp_badv;
    logic        m_timer, exp_int, exp_trap, exp_bvalid;
    int          errors = 0;
    int          cycles = 0;

    cp0_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= 4000) begin
            $display("Timeout: stimulus did not finish within 4000 cycles");
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] wr_mask(input logic [4:0] a);
        case (a)
            5'd0:        return 32'h0000000F;
            5'd2, 5'd3:  return 32'h3FFFFFC6;   // PFN, D and V.
            5'd9, 5'd11, 5'd14: return 32'hFFFFFFFF;
            5'd10:       return 32'hFFFFE000;
            5'd12:       return 32'h00000013;   // UM, EXL, IE.
            5'd13:       return 32'h00000300;
            5'd15:       return 32'h3FFFF000;
            default:     return 32'h0;
        endcase
    endfunction

    always_comb begin
        int idx;
        idx = 6;
        for (int i = 5; i >= 0; i--) begin
            if (exc_flags_i[i]) idx = i;
        end
        exp_int = commit_valid_i && m[12][0] && !m[12][1]
                  && ((|hw_int_i) || (|m[13][9:8]) || m_timer);
        exp_trap   = exp_int || (commit_valid_i && idx < 6);
        exp_bvalid = commit_valid_i && !exp_int && (idx == 0 || idx == 5);
        exp_badv   = (idx == 0) ? commit_pc_i : mem_addr_i;
        case (idx)
            0:       exp_code = EXC_ADEL;
            1:       exp_code = EXC_RI;
            2:       exp_code = EXC_SYS;
            3:       exp_code = EXC_BP;
            4:       exp_code = EXC_OV;
            default: exp_code = store_i ? EXC_ADES : EXC_ADEL;
        endcase
        if (exp_int) exp_code = EXC_INT;
        exp_rd = m[rd_addr_i];
        if (rd_addr_i == CP0_CAUSE) exp_rd = exp_rd | {16'b0, hw_int_i, 10'b0};
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) m[i] <= 32'b0;
            m[12]   <= `CP0_STATUS_RESET & 32'h13;
            m[15]   <= `CP0_EBASE_RESET;
            known   <= ~32'h0000450D;           // Index, EntryLo, BadVAddr, EntryHi, EPC.
            m_timer <= 1'b0;
        end else begin
            m[9] <= m[9] + 32'd1;
            if (m[11] != 32'b0 && m[11] == m[9]) m_timer <= 1'b1;
            if (we_i) begin
                m[wr_addr_i] <= (m[wr_addr_i] & ~wr_mask(wr_addr_i))
                                | (wr_data_i & wr_mask(wr_addr_i));
                if (wr_mask(wr_addr_i) != 32'b0) known[wr_addr_i] <= 1'b1;
                if (wr_addr_i == CP0_COMPARE) m_timer <= 1'b0;
            end
            if (exp_trap) begin
                m[12][1]   <= 1'b1;
                m[13][31]  <= commit_bd_i;
                m[13][6:2] <= exp_code;
                m[14]      <= commit_bd_i ? commit_pc_i - 32'd4 : commit_pc_i;
                known[14]  <= 1'b1;
                if (exp_bvalid) begin
                    m[8]     <= exp_badv;
                    known[8] <= 1'b1;
                end
            end else if (commit_valid_i && eret_i) begin
                m[12][1] <= 1'b0;
            end
        end
    end

    task automatic report_mismatch(input string msg);
        errors++;
        $display("Mismatch at %0t: %s", $time, msg);
    endtask

    a_rd: assert property (@(posedge clk) disable iff (!rst_n)
        !known[rd_addr_i] || rd_data_o === exp_rd) else report_mismatch("rd_data_o");
    a_trap: assert property (@(posedge clk) disable iff (!rst_n)
        trap_o === exp_trap) else report_mismatch("trap_o");
    a_code: assert property (@(posedge clk) disable iff (!rst_n)
        !exp_trap || trap_code_o === exp_code) else report_mismatch("trap_code_o");
    a_vec: assert property (@(posedge clk) disable iff (!rst_n)
        trap_vector_o === m[15] + {20'b0, `EXC_VECTOR_OFFSET}) else report_mismatch("vector");
    a_eret: assert property (@(posedge clk) disable iff (!rst_n)
        !known[14] || eret_target_o === m[14]) else report_mismatch("eret_target_o");
    a_um: assert property (@(posedge clk) disable iff (!rst_n)
        user_mode_o === (m[12][4] && !m[12][1])) else report_mismatch("user_mode_o");
    a_timer: assert property (@(posedge clk) disable iff (!rst_n)
        UUT.st.timer_int === m_timer) else report_mismatch("timer_int");
    a_tlb: assert property (@(posedge clk) disable iff (!rst_n)
        !(known[0] && known[2] && known[3] && known[10]) || tlb_config_o ===
        {m[10][31:13], m[3][29:6], m[3][2:1], m[2][29:6], m[2][2:1], m[0][3:0]})
        else report_mismatch("tlb_config_o");

    task automatic write_reg(input logic [4:0] a, input logic [31:0] d);
        @(negedge clk);
        we_i      = 1'b1;
        wr_addr_i = cp0_reg_e'(a);
        wr_data_i = d;
        @(negedge clk);
        we_i      = 1'b0;
        rd_addr_i = cp0_reg_e'(a);      // Read back what was just written.
    endtask

    task automatic random_step(input bit commits);
        logic [31:0] flags_rnd;
        logic [31:0] int_rnd;
        @(negedge clk);
        flags_rnd      = $urandom & $urandom & $urandom;
        int_rnd        = $urandom;
        rd_addr_i      = commits ? cp0_reg_e'($urandom_range(0, 31)) : wr_addr_i;
        we_i           = commits ? ($urandom_range(0, 7) == 0) : ($urandom_range(0, 1) == 1);
        wr_addr_i      = cp0_reg_e'($urandom_range(0, commits ? 15 : 31));
        wr_data_i      = $urandom;
        commit_valid_i = commits && $urandom_range(0, 1);
        exc_flags_i    = flags_rnd[EXC_FLAG_COUNT-1:0];
        store_i        = ($urandom_range(0, 1) == 1);
        commit_pc_i    = $urandom & 32'hFFFFFFFC;
        mem_addr_i     = $urandom;
        commit_bd_i    = ($urandom_range(0, 1) == 1);
        eret_i         = ($urandom_range(0, 3) == 0);
        hw_int_i       = ($urandom_range(0, 3) == 0) ? int_rnd[`HW_INT_LINES-1:0] : '0;
    endtask

    initial begin
        void'($urandom(32'h3dbe));
        rst_n = 1'b0;
        we_i = 1'b0;
        wr_addr_i = CP0_INDEX;
        wr_data_i = 32'b0;
        rd_addr_i = CP0_INDEX;
        hw_int_i = '0;
        commit_valid_i = 1'b0;
        exc_flags_i = '0;
        store_i = 1'b0;
        commit_pc_i = 32'b0;
        mem_addr_i = 32'b0;
        commit_bd_i = 1'b0;
        eret_i = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk) rst_n = 1'b1;
        for (int a = 0; a < 16; a++) write_reg(a[4:0], $urandom);
        repeat (300) random_step(1'b0);
        we_i = 1'b0;
        for (int k = 0; k < 3; k++) begin
            write_reg(5'd9, 32'd1000);
            write_reg(5'd11, 32'd1010 + k * 5);
            rd_addr_i = CP0_COUNT;
            repeat (30) @(negedge clk);
            write_reg(5'd11, 32'd0);    // Ack drops the timer.
        end
        repeat (1600) random_step(1'b1);
        @(negedge clk);
        $display("Checks finished: %0d errors in %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: common/cp0_cfg.svh
`ifndef CP0_CFG_SVH
`define CP0_CFG_SVH

// Status comes out of reset with CU0 set and everything else clear.
`define CP0_STATUS_RESET 32'h10000000

// EBase reads back with bits 31:30 fixed to 2'b10.
`define CP0_EBASE_RESET 32'h80000000

// General exception entry, relative to EBase.
`define EXC_VECTOR_OFFSET 12'h180

`define HW_INT_LINES 6
`define TLB_INDEX_BITS 4

// EntryLo PFN sits in bits 29:6.
`define CP0_PFN_BITS 24

// EntryHi VPN2 sits in bits 31:13.
`define CP0_VPN2_BITS 19

`endif

// File: common/cp0_if.sv
interface trap_write_if;
    import exc_pkg::*;

    logic        trap_en;
    exc_code_e   trap_code;
    logic [31:0] trap_epc;
    logic        trap_bd;
    logic [31:0] trap_bad_vaddr;
    logic        trap_bad_valid;
    logic        eret;

    modport trap (
        output trap_en, trap_code, trap_epc, trap_bd,
        output trap_bad_vaddr, trap_bad_valid, eret
    );

    modport regs (
        input trap_en, trap_code, trap_epc, trap_bd,
        input trap_bad_vaddr, trap_bad_valid, eret
    );
endinterface

interface cp0_state_if;
    logic        exl;
    logic        ie;
    logic        user_mode;
    logic [31:0] ebase;
    logic [31:0] epc;
    logic [1:0]  sw_int;
    logic        timer_int;

    modport regs (output exl, ie, user_mode, ebase, epc, sw_int, timer_int);
    modport intr (input exl, ie, sw_int, timer_int);
    modport trap (input ebase, epc);
endinterface

// File: common/cp0_reg_pkg.sv
`include "cp0_cfg.svh"

package cp0_reg_pkg;

    typedef enum logic [4:0] {
        CP0_INDEX    = 5'd0,
        CP0_ENTRYLO0 = 5'd2,
        CP0_ENTRYLO1 = 5'd3,
        CP0_BADVADDR = 5'd8,
        CP0_COUNT    = 5'd9,
        CP0_ENTRYHI  = 5'd10,
        CP0_COMPARE  = 5'd11,
        CP0_STATUS   = 5'd12,
        CP0_CAUSE    = 5'd13,
        CP0_EPC      = 5'd14,
        CP0_EBASE    = 5'd15
    } cp0_reg_e;

    typedef struct packed {
        logic [`CP0_VPN2_BITS-1:0]  vpn2;
        logic [`CP0_PFN_BITS-1:0]   pfn1;
        logic [1:0]                 dv1;    // D and V of EntryLo1.
        logic [`CP0_PFN_BITS-1:0]   pfn0;
        logic [1:0]                 dv0;
        logic [`TLB_INDEX_BITS-1:0] index;
    } tlb_config_t;

endpackage

// File: common/exc_pkg.sv
package exc_pkg;

    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_SYS  = 5'd8,
        EXC_BP   = 5'd9,
        EXC_RI   = 5'd10,
        EXC_OV   = 5'd12
    } exc_code_e;

    // Fault flag positions; lower index means higher priority.
    localparam int EXC_FLAG_FETCH_ADEL = 0;
    localparam int EXC_FLAG_RI         = 1;
    localparam int EXC_FLAG_SYS        = 2;
    localparam int EXC_FLAG_BP         = 3;
    localparam int EXC_FLAG_OV         = 4;
    localparam int EXC_FLAG_DATA_ADEL  = 5;

    localparam int EXC_FLAG_COUNT = 6;

endpackage

// File: cp0/cp0_regs.sv
`include "cp0_cfg.svh"

module cp0_regs (
    input  logic                      clk,
    input  logic                      rst_n,
    input  cp0_reg_pkg::cp0_reg_e     rd_addr_i,
    output logic [31:0]               rd_data_o,
    input  logic                      we_i,
    input  cp0_reg_pkg::cp0_reg_e     wr_addr_i,
    input  logic [31:0]               wr_data_i,
    input  logic [`HW_INT_LINES-1:0]  hw_int_i,
    output cp0_reg_pkg::tlb_config_t  tlb_config_o,
    trap_write_if.regs                trap,
    cp0_state_if.regs                 state
);
    import cp0_reg_pkg::*;
    import exc_pkg::*;

    localparam logic [31:0] STATUS_RST = `CP0_STATUS_RESET;
    localparam logic [31:0] EBASE_RST  = `CP0_EBASE_RESET;

    logic [`TLB_INDEX_BITS-1:0] index_q;
    logic [`CP0_PFN_BITS-1:0]   lo0_pfn_q;
    logic [1:0]                 lo0_dv_q;
    logic [`CP0_PFN_BITS-1:0]   lo1_pfn_q;
    logic [1:0]                 lo1_dv_q;
    logic [`CP0_VPN2_BITS-1:0]  hi_vpn2_q;
    logic [31:0]                badvaddr_q;
    logic [31:0]                epc_q;

    logic [31:0] count_q;
    logic [31:0] compare_q;
    logic        timer_int_q;
    logic        status_um_q;
    logic        status_exl_q;
    logic        status_ie_q;
    logic        cause_bd_q;
    exc_code_e   cause_code_q;
    logic [1:0]  cause_sw_q;
    logic [17:0] ebase_q;       // EBase bits 29:12.

    always_comb begin
        case (rd_addr_i)
            CP0_INDEX:    rd_data_o = {28'b0, index_q};
            CP0_ENTRYLO0: rd_data_o = {2'b0, lo0_pfn_q, 3'b0, lo0_dv_q, 1'b0};
            CP0_ENTRYLO1: rd_data_o = {2'b0, lo1_pfn_q, 3'b0, lo1_dv_q, 1'b0};
            CP0_BADVADDR: rd_data_o = badvaddr_q;
            CP0_COUNT:    rd_data_o = count_q;
            CP0_ENTRYHI:  rd_data_o = {hi_vpn2_q, 13'b0};
            CP0_COMPARE:  rd_data_o = compare_q;
            CP0_STATUS:   rd_data_o = {27'b0, status_um_q, 2'b0, status_exl_q, status_ie_q};
            CP0_CAUSE: begin
                rd_data_o = {cause_bd_q, 15'b0, hw_int_i, cause_sw_q, 1'b0,
                             cause_code_q, 2'b00};  // IP7..2 are the live lines.
            end
            CP0_EPC:      rd_data_o = epc_q;
            CP0_EBASE:    rd_data_o = {2'b10, ebase_q, 12'b0};
            default:      rd_data_o = 32'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            case (wr_addr_i)
                CP0_INDEX: index_q <= wr_data_i[`TLB_INDEX_BITS-1:0];
                CP0_ENTRYLO0: begin
                    lo0_pfn_q <= wr_data_i[29:6];
                    lo0_dv_q  <= wr_data_i[2:1];
                end
                CP0_ENTRYLO1: begin
                    lo1_pfn_q <= wr_data_i[29:6];
                    lo1_dv_q  <= wr_data_i[2:1];
                end
                CP0_ENTRYHI: hi_vpn2_q <= wr_data_i[31:13];
                CP0_EPC:     epc_q <= wr_data_i;
                default: ;
            endcase
        end
        if (trap.trap_en) begin
            epc_q <= trap.trap_epc;     // Trap overrides a same-cycle write.
            if (trap.trap_bad_valid) begin
                badvaddr_q <= trap.trap_bad_vaddr;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q      <= 32'b0;
            compare_q    <= 32'b0;
            timer_int_q  <= 1'b0;
            status_um_q  <= STATUS_RST[4];
            status_exl_q <= STATUS_RST[1];
            status_ie_q  <= STATUS_RST[0];
            cause_bd_q   <= 1'b0;
            cause_code_q <= EXC_INT;
            cause_sw_q   <= 2'b0;
            ebase_q      <= EBASE_RST[29:12];
        end else begin
            count_q <= count_q + 32'd1;
            if (compare_q != 32'b0 && compare_q == count_q) begin
                timer_int_q <= 1'b1;
            end
            if (we_i) begin
                case (wr_addr_i)
                    CP0_COUNT: count_q <= wr_data_i;
                    CP0_COMPARE: begin
                        compare_q   <= wr_data_i;
                        timer_int_q <= 1'b0;    // Writing Compare acks the timer.
                    end
                    CP0_STATUS: begin
                        status_um_q  <= wr_data_i[4];
                        status_exl_q <= wr_data_i[1];
                        status_ie_q  <= wr_data_i[0];
                    end
                    CP0_CAUSE: cause_sw_q <= wr_data_i[9:8];
                    CP0_EBASE: ebase_q <= wr_data_i[29:12];
                    default: ;
                endcase
            end
            if (trap.trap_en) begin
                status_exl_q <= 1'b1;
                cause_bd_q   <= trap.trap_bd;
                cause_code_q <= trap.trap_code;
            end else if (trap.eret) begin
                status_exl_q <= 1'b0;
            end
        end
    end

    assign state.exl       = status_exl_q;
    assign state.ie        = status_ie_q;
    assign state.user_mode = status_um_q && !status_exl_q;
    assign state.ebase     = {2'b10, ebase_q, 12'b0};
    assign state.epc       = epc_q;
    assign state.sw_int    = cause_sw_q;
    assign state.timer_int = timer_int_q;

    assign tlb_config_o = {hi_vpn2_q, lo1_pfn_q, lo1_dv_q, lo0_pfn_q, lo0_dv_q, index_q};

endmodule

// File: files.f
+incdir+common
common/cp0_reg_pkg.sv
common/exc_pkg.sv
common/cp0_if.sv
cp0/cp0_regs.sv
source/exc_prioritizer.sv
source/int_detector.sv
source/trap_unit.sv
source/cp0_top.sv
bench/cp0_tb.sv

// File: source/cp0_top.sv
`include "cp0_cfg.svh"

module cp0_top (
    input  logic                               clk,
    input  logic                               rst_n,
    input  cp0_reg_pkg::cp0_reg_e              rd_addr_i,
    output logic [31:0]                        rd_data_o,
    input  logic                               we_i,
    input  cp0_reg_pkg::cp0_reg_e              wr_addr_i,
    input  logic [31:0]                        wr_data_i,
    input  logic [`HW_INT_LINES-1:0]           hw_int_i,
    output cp0_reg_pkg::tlb_config_t           tlb_config_o,
    input  logic                               commit_valid_i,
    input  logic [exc_pkg::EXC_FLAG_COUNT-1:0] exc_flags_i,
    input  logic                               store_i,
    input  logic [31:0]                        commit_pc_i,
    input  logic [31:0]                        mem_addr_i,
    input  logic                               commit_bd_i,
    input  logic                               eret_i,
    output logic                               trap_o,
    output exc_pkg::exc_code_e                 trap_code_o,
    output logic [31:0]                        trap_vector_o,
    output logic [31:0]                        eret_target_o,
    output logic                               user_mode_o
);
    import exc_pkg::*;

    logic        exc_valid;
    exc_code_e   exc_code;
    logic [31:0] bad_vaddr;
    logic        bad_valid;
    logic        int_pending;

    trap_write_if tw ();
    cp0_state_if  st ();

    cp0_regs u_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_addr_i    (rd_addr_i),
        .rd_data_o    (rd_data_o),
        .we_i         (we_i),
        .wr_addr_i    (wr_addr_i),
        .wr_data_i    (wr_data_i),
        .hw_int_i     (hw_int_i),
        .tlb_config_o (tlb_config_o),
        .trap         (tw.regs),
        .state        (st.regs)
    );

    exc_prioritizer u_exc (
        .commit_valid_i (commit_valid_i),
        .exc_flags_i    (exc_flags_i),
        .store_i        (store_i),
        .commit_pc_i    (commit_pc_i),
        .mem_addr_i     (mem_addr_i),
        .exc_valid_o    (exc_valid),
        .exc_code_o     (exc_code),
        .bad_vaddr_o    (bad_vaddr),
        .bad_valid_o    (bad_valid)
    );

    int_detector u_int (
        .hw_int_i       (hw_int_i),
        .state          (st.intr),
        .commit_valid_i (commit_valid_i),
        .int_pending_o  (int_pending)
    );

    trap_unit u_trap (
        .commit_valid_i (commit_valid_i),
        .commit_pc_i    (commit_pc_i),
        .commit_bd_i    (commit_bd_i),
        .eret_i         (eret_i),
        .int_pending_i  (int_pending),
        .exc_valid_i    (exc_valid),
        .exc_code_i     (exc_code),
        .bad_vaddr_i    (bad_vaddr),
        .bad_valid_i    (bad_valid),
        .trap_o         (trap_o),
        .trap_code_o    (trap_code_o),
        .trap_vector_o  (trap_vector_o),
        .eret_target_o  (eret_target_o),
        .tw             (tw.trap),
        .state          (st.trap)
    );

    assign user_mode_o = st.user_mode;

endmodule

// File: source/exc_prioritizer.sv
module exc_prioritizer (
    input  logic                                commit_valid_i,
    input  logic [exc_pkg::EXC_FLAG_COUNT-1:0]  exc_flags_i,
    input  logic                                store_i,
    input  logic [31:0]                         commit_pc_i,
    input  logic [31:0]                         mem_addr_i,
    output logic                                exc_valid_o,
    output exc_pkg::exc_code_e                  exc_code_o,
    output logic [31:0]                         bad_vaddr_o,
    output logic                                bad_valid_o
);
    import exc_pkg::*;

    always_comb begin
        exc_valid_o = commit_valid_i && (|exc_flags_i);
        exc_code_o  = EXC_INT;
        bad_vaddr_o = 32'b0;
        bad_valid_o = 1'b0;
        if (exc_flags_i[EXC_FLAG_FETCH_ADEL]) begin
            exc_code_o  = EXC_ADEL;
            bad_vaddr_o = commit_pc_i;    // Fetch fault blames the PC.
            bad_valid_o = commit_valid_i;
        end else if (exc_flags_i[EXC_FLAG_RI]) begin
            exc_code_o = EXC_RI;
        end else if (exc_flags_i[EXC_FLAG_SYS]) begin
            exc_code_o = EXC_SYS;
        end else if (exc_flags_i[EXC_FLAG_BP]) begin
            exc_code_o = EXC_BP;
        end else if (exc_flags_i[EXC_FLAG_OV]) begin
            exc_code_o = EXC_OV;
        end else if (exc_flags_i[EXC_FLAG_DATA_ADEL]) begin
            exc_code_o  = store_i ? EXC_ADES : EXC_ADEL;
            bad_vaddr_o = mem_addr_i;
            bad_valid_o = commit_valid_i;
        end
    end

endmodule

// File: source/int_detector.sv
`include "cp0_cfg.svh"

module int_detector (
    input  logic                     [`HW_INT_LINES-1:0] hw_int_i,
    cp0_state_if.intr                state,
    input  logic                     commit_valid_i,
    output logic                     int_pending_o
);
    logic any_req;
    logic int_enabled;

    // Any source counts without per-line masks.
    assign any_req = (|hw_int_i) || (|state.sw_int) || state.timer_int;

    assign int_enabled = state.ie && !state.exl;

    assign int_pending_o = commit_valid_i && int_enabled && any_req;

endmodule

// File: source/trap_unit.sv
`include "cp0_cfg.svh"

module trap_unit (
    input  logic               commit_valid_i,
    input  logic [31:0]        commit_pc_i,
    input  logic               commit_bd_i,
    input  logic               eret_i,
    input  logic               int_pending_i,
    input  logic               exc_valid_i,
    input  exc_pkg::exc_code_e exc_code_i,
    input  logic [31:0]        bad_vaddr_i,
    input  logic               bad_valid_i,
    output logic               trap_o,
    output exc_pkg::exc_code_e trap_code_o,
    output logic [31:0]        trap_vector_o,
    output logic [31:0]        eret_target_o,
    trap_write_if.trap         tw,
    cp0_state_if.trap          state
);
    import exc_pkg::*;

    logic [31:0] epc_val;

    assign trap_o      = commit_valid_i && (int_pending_i || exc_valid_i);
    assign trap_code_o = int_pending_i ? EXC_INT : exc_code_i;

    // Restart at the branch when the fault is in its delay slot.
    assign epc_val = commit_bd_i ? commit_pc_i - 32'd4 : commit_pc_i;

    assign trap_vector_o = state.ebase + {20'b0, `EXC_VECTOR_OFFSET};
    assign eret_target_o = state.epc;

    assign tw.trap_en        = trap_o;
    assign tw.trap_code      = trap_code_o;
    assign tw.trap_epc       = epc_val;
    assign tw.trap_bd        = commit_bd_i;
    assign tw.trap_bad_vaddr = bad_vaddr_i;
    assign tw.trap_bad_valid = bad_valid_i && !int_pending_i;  // Dropped under an interrupt.
    assign tw.eret           = commit_valid_i && eret_i && !trap_o;

endmodule
